// ==== rtl/fb_video_pkg.sv ====
////////////////////////////////////////
// frame-buffer video package
// widths, pixel and word types, raster
// and memory-port structs
////////////////////////////////////////

package fb_video_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   // zbt word address and data
   localparam int ADDR_W = 19;
   localparam int WORD_W = 36;

   // one pixel is three 6-bit colour fields, two per word
   localparam int CHAN_W = 6;
   localparam int PIX_W = 3 * CHAN_W;

   // raster counters
   localparam int HCOUNT_W = 11;
   localparam int VCOUNT_W = 10;

   // pixels between fetch forecast and display
   localparam int FETCH_AHEAD = 8;

   ////////////////////////////////////////
   // types
   ////////////////////////////////////////

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [PIX_W-1:0]  pixel_t;

   // raster position and timing, syncs active low
   typedef struct packed {
      logic [HCOUNT_W-1:0] hcount;
      logic [VCOUNT_W-1:0] vcount;
      logic                hsync;
      logic                vsync;
      logic                blank;
   } raster_t;

   // one request on the zbt port
   typedef struct packed {
      addr_t addr;
      logic  we;
      word_t wdata;
   } mem_req_t;

endpackage

// ==== rtl/raster_timing.sv ====
////////////////////////////////////////
// raster timing generator
// pixel and line counters with hsync,
// vsync and blank for the display
////////////////////////////////////////

`timescale 1ns/100ps

module raster_timing #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806
) (
   input  logic                  clk,
   input  logic                  rst_n,
   output fb_video_pkg::raster_t raster
);

   localparam int HW = fb_video_pkg::HCOUNT_W;
   localparam int VW = fb_video_pkg::VCOUNT_W;

   // events fire one count early so the registered outputs line up
   localparam logic [HW-1:0] H_BLANK_AT = HW'(H_ACTIVE - 1);
   localparam logic [HW-1:0] H_SON_AT   = HW'(H_SYNC_START - 1);
   localparam logic [HW-1:0] H_SOFF_AT  = HW'(H_SYNC_END - 1);
   localparam logic [HW-1:0] H_LAST     = HW'(H_TOTAL - 1);
   localparam logic [VW-1:0] V_BLANK_AT = VW'(V_ACTIVE - 1);
   localparam logic [VW-1:0] V_SON_AT   = VW'(V_SYNC_START - 1);
   localparam logic [VW-1:0] V_SOFF_AT  = VW'(V_SYNC_END - 1);
   localparam logic [VW-1:0] V_LAST     = VW'(V_TOTAL - 1);

   logic hblank;
   logic vblank;
   logic hreset;
   logic vreset;
   logic next_hblank;
   logic next_vblank;

   // end of line, and end of frame on the last line
   assign hreset = (raster.hcount == H_LAST);
   assign vreset = hreset && (raster.vcount == V_LAST);

   always_comb
   begin
      // horizontal blank runs from the end of active to the line wrap
      next_hblank = hblank;
      if (hreset)
         next_hblank = 1'b0;
      else if (raster.hcount == H_BLANK_AT)
         next_hblank = 1'b1;
      // vertical blank switches only at a line wrap
      next_vblank = vblank;
      if (vreset)
         next_vblank = 1'b0;
      else if (hreset && (raster.vcount == V_BLANK_AT))
         next_vblank = 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         raster <= '{hcount: '0, vcount: '0, hsync: 1'b1, vsync: 1'b1, blank: 1'b0};
         hblank <= 1'b0;
         vblank <= 1'b0;
      end
      else
      begin
         raster.hcount <= hreset ? '0 : raster.hcount + 1'b1;
         if (hreset)
            raster.vcount <= vreset ? '0 : raster.vcount + 1'b1;
         // syncs are active low
         if (raster.hcount == H_SON_AT)
            raster.hsync <= 1'b0;
         else if (raster.hcount == H_SOFF_AT)
            raster.hsync <= 1'b1;
         if (hreset && (raster.vcount == V_SON_AT))
            raster.vsync <= 1'b0;
         else if (hreset && (raster.vcount == V_SOFF_AT))
            raster.vsync <= 1'b1;
         hblank <= next_hblank;
         vblank <= next_vblank;
         raster.blank <= next_vblank | next_hblank;
      end
   end

   // line wrap must keep the count inside the line
   a_hcount_range : assert property (
      @(posedge clk) disable iff (!rst_n) raster.hcount < H_TOTAL);

endmodule

// ==== rtl/pattern_writer.sv ====
////////////////////////////////////////
// test-pattern writer
// bar pattern words from a free-running
// counter, offered as write requests
////////////////////////////////////////

`timescale 1ns/100ps

module pattern_writer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pat_sel,
   output fb_video_pkg::mem_req_t wr_req
);

   // counter runs every cycle, used or not
   logic [31:0] count;
   // five counter bits per 9-bit slice of the word
   logic [4:0]  chunk;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         count <= '0;
      else
         count <= count + 1'b1;
   end

   // pat_sel picks the shorter bar period
   assign chunk = pat_sel ? count[7:3] : count[8:4];

   always_comb
   begin
      // low counter bits sweep the whole buffer
      wr_req.addr = count[fb_video_pkg::ADDR_W-1:0];
      // always a write, the arbiter decides if it goes out
      wr_req.we = 1'b1;
      // four copies of chunk with four zero bits each
      wr_req.wdata = {4{chunk, 4'b0000}};
   end

endmodule

// ==== rtl/vram_arbiter.sv ====
////////////////////////////////////////
// vram port arbiter
// display fetches first, pattern writes
// in blanking, idle reads otherwise
////////////////////////////////////////

`timescale 1ns/100ps

module vram_arbiter (
   input  logic                   clk,
   input  fb_video_pkg::raster_t  raster,
   input  logic                   hold,
   input  logic                   fetch,
   input  fb_video_pkg::addr_t    fetch_addr,
   input  fb_video_pkg::mem_req_t wr_req,
   output fb_video_pkg::mem_req_t mem_req
);

   always_comb
   begin
      // fetch and idle reads both use the fetch address
      mem_req.addr  = fetch_addr;
      mem_req.we    = 1'b0;
      mem_req.wdata = wr_req.wdata;
      // look-ahead reads inside blanking win over writes
      // a write that loses to a fetch is dropped
      if (!fetch && raster.blank && !hold)
         mem_req = wr_req;
   end

   // a display read and a write never share the port
   a_fetch_no_write : assert property (
      @(posedge clk) fetch |-> !mem_req.we);

endmodule

// ==== rtl/vram_reader.sv ====
////////////////////////////////////////
// vram display reader
// forecasts the raster, fetches one word
// per two pixels and unpacks it
////////////////////////////////////////

`timescale 1ns/100ps

module vram_reader #(
   parameter int H_ACTIVE = 1024,
   parameter int H_TOTAL  = 1344,
   parameter int V_TOTAL  = 806
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  fb_video_pkg::raster_t raster,
   input  fb_video_pkg::word_t   mem_rdata,
   output logic                  fetch,
   output fb_video_pkg::addr_t   fetch_addr,
   output fb_video_pkg::pixel_t  pixel
);

   localparam int HW = fb_video_pkg::HCOUNT_W;
   localparam int VW = fb_video_pkg::VCOUNT_W;
   localparam int PW = fb_video_pkg::PIX_W;
   localparam int WW = fb_video_pkg::WORD_W;
   // column bits within the active line, H_ACTIVE is a power of two
   localparam int HA_BITS = $clog2(H_ACTIVE);
   localparam logic [HW-1:0] H_AHEAD = HW'(fb_video_pkg::FETCH_AHEAD);
   localparam logic [HW-1:0] H_WRAP  = HW'(H_TOTAL - fb_video_pkg::FETCH_AHEAD);
   localparam logic [HW-1:0] H_END   = HW'(H_ACTIVE);
   localparam logic [VW-1:0] V_LAST  = VW'(V_TOTAL - 1);
   // word steps on odd pixels, two memory cycles already spent
   localparam int HOLD_STAGES = (fb_video_pkg::FETCH_AHEAD - 2) / 2;

   logic [HW-1:0]       hcount_f;
   logic [VW-1:0]       vcount_f;
   logic                wrap;
   logic [1:0]          fetch_d;
   fb_video_pkg::word_t rd_latched;
   fb_video_pkg::word_t hold_q [HOLD_STAGES];

   ////////////////////////////////////////
   // forecast and fetch
   ////////////////////////////////////////

   // position FETCH_AHEAD pixels later, wrapping into next line/frame
   assign wrap = (raster.hcount >= H_WRAP);
   assign hcount_f = wrap ? raster.hcount - H_WRAP : raster.hcount + H_AHEAD;
   assign vcount_f = !wrap ? raster.vcount
                   : (raster.vcount == V_LAST) ? '0 : raster.vcount + 1'b1;

   // one read per even pixel of the active line
   assign fetch = !hcount_f[0] && (hcount_f < H_END);
   assign fetch_addr = fb_video_pkg::addr_t'({vcount_f, hcount_f[HA_BITS-1:1]});

   ////////////////////////////////////////
   // read data and unpack
   ////////////////////////////////////////

   // marker follows the two-cycle read latency
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         fetch_d <= '0;
      else
         fetch_d <= {fetch_d[0], fetch};
   end

   // catch the word in the cycle it is on the bus
   always_ff @(posedge clk)
   begin
      if (fetch_d[1])
         rd_latched <= mem_rdata;
   end

   // hold chain moves on odd pixels so the last stage covers an even/odd pair
   always_ff @(posedge clk)
   begin
      if (raster.hcount[0])
      begin
         hold_q[0] <= rd_latched;
         for (int i = 1; i < HOLD_STAGES; i++)
            hold_q[i] <= hold_q[i-1];
      end
   end

   // even pixel takes the upper half
   assign pixel = raster.hcount[0] ? hold_q[HOLD_STAGES-1][PW-1:0]
                                   : hold_q[HOLD_STAGES-1][WW-1:PW];

   // reads come on even forecasts only, never back to back
   a_fetch_even : assert property (
      @(posedge clk) disable iff (!rst_n) fetch |-> !hcount_f[0] ##1 !fetch);

endmodule

// ==== rtl/video_out.sv ====
////////////////////////////////////////
// video output stage
// bar override, registered RGB, blank_b
// and syncs
////////////////////////////////////////

`timescale 1ns/100ps

module video_out (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          bars,
   input  fb_video_pkg::raster_t         raster,
   input  fb_video_pkg::pixel_t          pixel,
   output logic [fb_video_pkg::CHAN_W+1:0] red,
   output logic [fb_video_pkg::CHAN_W+1:0] green,
   output logic [fb_video_pkg::CHAN_W+1:0] blue,
   output logic                          hsync,
   output logic                          vsync,
   output logic                          blank_b
);

   localparam int CW = fb_video_pkg::CHAN_W;
   localparam int PW = fb_video_pkg::PIX_W;

   fb_video_pkg::pixel_t pix_sel;
   fb_video_pkg::pixel_t pix_q;

   always_comb
   begin
      pix_sel = pixel;
      if (bars)
      begin
         // vertical bars, 64 columns wide, in red only
         pix_sel = '0;
         pix_sel[PW-1 -: 3] = raster.hcount[8:6];
      end
   end

   always_ff @(posedge clk)
      pix_q <= pix_sel;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hsync   <= 1'b1;
         vsync   <= 1'b1;
         blank_b <= 1'b0;
      end
      else
      begin
         hsync   <= raster.hsync;
         vsync   <= raster.vsync;
         blank_b <= ~raster.blank;
      end
   end

   // dac takes 8-bit channels, low two bits zero
   assign red   = {pix_q[3*CW-1:2*CW], 2'b00};
   assign green = {pix_q[2*CW-1:CW], 2'b00};
   assign blue  = {pix_q[CW-1:0], 2'b00};

endmodule

// ==== rtl/fb_video_top.sv ====
////////////////////////////////////////
// frame-buffer display engine top
// raster, pattern writer, zbt arbiter,
// display reader and VGA output stage
////////////////////////////////////////

`timescale 1ns/100ps

module fb_video_top #(
   parameter int H_ACTIVE     = 1024,
   parameter int H_SYNC_START = 1048,
   parameter int H_SYNC_END   = 1184,
   parameter int H_TOTAL      = 1344,
   parameter int V_ACTIVE     = 768,
   parameter int V_SYNC_START = 777,
   parameter int V_SYNC_END   = 783,
   parameter int V_TOTAL      = 806
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            pat_sel,
   input  logic                            hold,
   input  logic                            bars,
   input  fb_video_pkg::word_t             mem_rdata,
   output fb_video_pkg::mem_req_t          mem_req,
   output logic [fb_video_pkg::CHAN_W+1:0] red,
   output logic [fb_video_pkg::CHAN_W+1:0] green,
   output logic [fb_video_pkg::CHAN_W+1:0] blue,
   output logic                            hsync,
   output logic                            vsync,
   output logic                            blank_b
);

   fb_video_pkg::raster_t  raster;
   fb_video_pkg::mem_req_t wr_req;
   fb_video_pkg::addr_t    fetch_addr;
   fb_video_pkg::pixel_t   pixel;
   logic                   fetch;

   // raster timing, shared by every block below
   raster_timing #(
      .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START),
      .H_SYNC_END(H_SYNC_END), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
      .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
   ) i_raster_timing (
      .clk(clk), .rst_n(rst_n), .raster(raster)
   );

   // pattern source for blank-time writes
   pattern_writer i_pattern_writer (
      .clk(clk), .rst_n(rst_n), .pat_sel(pat_sel), .wr_req(wr_req)
   );

   // single zbt port
   vram_arbiter i_vram_arbiter (
      .clk(clk), .raster(raster), .hold(hold), .fetch(fetch),
      .fetch_addr(fetch_addr), .wr_req(wr_req), .mem_req(mem_req)
   );

   vram_reader #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)
   ) i_vram_reader (
      .clk(clk), .rst_n(rst_n), .raster(raster), .mem_rdata(mem_rdata),
      .fetch(fetch), .fetch_addr(fetch_addr), .pixel(pixel)
   );

   // one register stage to the pins
   video_out i_video_out (
      .clk(clk), .rst_n(rst_n), .bars(bars), .raster(raster), .pixel(pixel),
      .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .blank_b(blank_b)
   );

endmodule

// ==== verification/fb_video_tb.sv ====
////////////////////////////////////////
// frame-buffer display engine testbench
// zbt memory model, case loop from the
// cases file, raster and pixel checks
////////////////////////////////////////

`timescale 1ns/100ps

module fb_video_tb;

   // small geometry so a frame is only 288 cycles
   localparam int H_ACTIVE     = 16;
   localparam int H_SYNC_START = 18;
   localparam int H_SYNC_END   = 20;
   localparam int H_TOTAL      = 24;
   localparam int V_ACTIVE     = 8;
   localparam int V_SYNC_START = 9;
   localparam int V_SYNC_END   = 10;
   localparam int V_TOTAL      = 12;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int MAX_CASES    = 16;
   localparam int FIELDS       = 7;
   localparam int CW           = fb_video_pkg::CHAN_W;
   localparam int PW           = fb_video_pkg::PIX_W;
   localparam int WW           = fb_video_pkg::WORD_W;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   pat_sel;
   logic                   hold;
   logic                   bars;
   fb_video_pkg::word_t    mem_rdata = '0;
   fb_video_pkg::mem_req_t mem_req;
   logic [CW+1:0]          red;
   logic [CW+1:0]          green;
   logic [CW+1:0]          blue;
   logic                   hsync;
   logic                   vsync;
   logic                   blank_b;

   // sparse zbt contents, unwritten words come from fill_word
   fb_video_pkg::word_t mem [fb_video_pkg::addr_t];
   fb_video_pkg::word_t rd_pipe = '0;
   int                  write_count = 0;
   logic [31:0]         case_mem [MAX_CASES*FIELDS];

   always #5 clk = ~clk;

   fb_video_top #(
      .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START),
      .H_SYNC_END(H_SYNC_END), .H_TOTAL(H_TOTAL),
      .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
      .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL)
   ) i_fb_video_top (
      .clk(clk), .rst_n(rst_n), .pat_sel(pat_sel), .hold(hold), .bars(bars),
      .mem_rdata(mem_rdata), .mem_req(mem_req),
      .red(red), .green(green), .blue(blue),
      .hsync(hsync), .vsync(vsync), .blank_b(blank_b)
   );

   ////////////////////////////////////////
   // reference rules
   ////////////////////////////////////////

   // background word, every address bit reaches the data
   function automatic fb_video_pkg::word_t fill_word(input fb_video_pkg::addr_t a);
      return {a ^ 19'h5a5a5, a[16:0] ^ 17'h1c3e7};
   endfunction

   function automatic fb_video_pkg::word_t read_mem(input fb_video_pkg::addr_t a);
      if (mem.exists(a))
         return mem[a];
      return fill_word(a);
   endfunction

   // four 9-bit slices, each five address bits over four zeros
   function automatic fb_video_pkg::word_t pattern_word(input fb_video_pkg::addr_t a,
                                                        input logic sel);
      fb_video_pkg::word_t w;
      int                  lsb;
      lsb = sel ? 3 : 4;
      w = '0;
      for (int s = 0; s < 4; s++)
         w[9*s+4 +: 5] = a[lsb +: 5];
      return w;
   endfunction

   ////////////////////////////////////////
   // memory model and port checks
   ////////////////////////////////////////

   // address taken on the edge after it appears, data out one edge later
   always @(posedge clk)
   begin
      rd_pipe   <= read_mem(mem_req.addr);
      mem_rdata <= #1 rd_pipe;
      if (mem_req.we)
      begin
         mem[mem_req.addr] = mem_req.wdata;
         write_count = write_count + 1;
      end
   end

   // every write must carry the pattern for its own address
   always @(posedge clk)
   begin
      if (rst_n && mem_req.we)
      begin
         if (hold)
            fail_run("a pattern write reached the memory port while hold was high");
         else
            check_word("mem_req.wdata", mem_req.wdata, pattern_word(mem_req.addr, pat_sel));
      end
   end

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_pixel(input string name, input fb_video_pkg::pixel_t got,
                              input fb_video_pkg::pixel_t exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_word(input string name, input fb_video_pkg::word_t got,
                             input fb_video_pkg::word_t exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got !== exp)
         fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
   endtask

   ////////////////////////////////////////
   // frame measurement
   ////////////////////////////////////////

   // frame boundary is the vsync fall seen at the outputs
   task automatic wait_vsync_fall();
      logic prev;
      logic now;
      int   cycles;
      prev = 1'b0;
      now = vsync;
      cycles = 0;
      while (!(prev && !now))
      begin
         if (cycles > 2 * FRAME_CYCLES)
            fail_run("timed out waiting for vsync to fall");
         @(negedge clk);
         prev = now;
         now = vsync;
         cycles++;
      end
   endtask

   // one vsync fall to the next, outputs sampled mid-cycle
   task automatic measure_frame(input logic use_bars, input int exp_pix,
                                input int exp_lines, input int exp_red12);
      fb_video_pkg::pixel_t got;
      fb_video_pkg::pixel_t exp;
      fb_video_pkg::word_t  word;
      logic [31:0]          col_bits;
      logic [CW-1:0]        bar_red;
      logic                 prev_blank_b;
      logic                 prev_hsync;
      logic                 prev_vsync;
      logic                 done;
      int                   col;
      int                   line;
      int                   hs_len;
      int                   vs_len;
      int                   cycles;
      prev_blank_b = 1'b0;
      prev_hsync = 1'b1;
      prev_vsync = 1'b0;
      done = 1'b0;
      col = 0;
      line = 0;
      hs_len = 0;
      // the fall sample itself was already seen
      vs_len = 1;
      cycles = 0;
      while (!done)
      begin
         if (cycles > 2 * FRAME_CYCLES)
            fail_run("timed out inside a frame, vsync stopped toggling");
         @(negedge clk);
         cycles++;
         if (blank_b)
         begin
            got = {red[CW+1:2], green[CW+1:2], blue[CW+1:2]};
            col_bits = col;
            if (use_bars)
            begin
               // red field is column bits 8 to 6, then zeros
               bar_red = {col_bits[8:6], 3'b000};
               exp = {bar_red, {(2*CW){1'b0}}};
            end
            else
            begin
               word = read_mem(fb_video_pkg::addr_t'(line * (H_ACTIVE / 2) + col / 2));
               // even column takes the upper half
               exp = col_bits[0] ? word[PW-1:0] : word[WW-1:PW];
            end
            check_pixel($sformatf("pixel line %0d column %0d", line, col), got, exp);
            check_count("rgb low bits", int'({red[1:0], green[1:0], blue[1:0]}), 0);
            if (use_bars && col == 12)
               check_count("red at column 12", int'(red), exp_red12);
            col++;
         end
         else if (prev_blank_b)
         begin
            check_count("active pixels per line", col, exp_pix);
            line++;
            col = 0;
         end
         if (!hsync)
            hs_len++;
         else if (!prev_hsync)
         begin
            check_count("hsync pulse length", hs_len, H_SYNC_END - H_SYNC_START);
            hs_len = 0;
         end
         if (vsync && !prev_vsync)
         begin
            check_count("vsync pulse length", vs_len, (V_SYNC_END - V_SYNC_START) * H_TOTAL);
            vs_len = 0;
         end
         else if (!vsync && prev_vsync)
            done = 1'b1;
         else if (!vsync)
            vs_len++;
         prev_blank_b = blank_b;
         prev_hsync = hsync;
         prev_vsync = vsync;
      end
      check_count("active lines per frame", line, exp_lines);
   endtask

   // controls change just after an edge, right behind a frame boundary
   task automatic run_case(input int n);
      int base;
      int frames;
      int snap_count;
      base = n * FIELDS;
      frames = int'(case_mem[base+3]);
      @(posedge clk);
      #1;
      pat_sel = case_mem[base][0];
      hold = case_mem[base+1][0];
      bars = case_mem[base+2][0];
      snap_count = write_count;
      for (int f = 0; f < frames; f++)
         measure_frame(bars, int'(case_mem[base+4]), int'(case_mem[base+5]),
                       int'(case_mem[base+6]));
      if (hold)
      begin
         // frozen buffer, not a single store reached the memory
         check_count("write count under hold", write_count, snap_count);
      end
      else
         check_count("pattern writes seen", (write_count > snap_count) ? 1 : 0, 1);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial
   begin
      int n;
      rst_n = 1'b1;
      pat_sel = 1'b0;
      hold = 1'b0;
      bars = 1'b0;
      for (int i = 0; i < MAX_CASES * FIELDS; i++)
         case_mem[i] = '1;
      $readmemh("verification/fb_video_cases.txt", case_mem);
      #1 rst_n = 1'b0;
      // reset values, still before the first clock edge
      #1;
      check_count("hsync in reset", int'(hsync), 1);
      check_count("vsync in reset", int'(vsync), 1);
      check_count("blank_b in reset", int'(blank_b), 0);
      check_count("mem_req.we in reset", int'(mem_req.we), 0);
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
      // skip frame 0, its first fetches predate reset release
      wait_vsync_fall();
      n = 0;
      while (n < MAX_CASES && case_mem[n*FIELDS] !== 32'hffffffff)
      begin
         run_case(n);
         n++;
      end
      if (n == 0)
         fail_run("no test cases were read from the cases file");
      else
         $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== verification/fb_video_cases.txt ====
// pat_sel hold bars frames active_pixels active_lines red_at_col12
// all values hex, one case per line, small 16x8 active geometry
0 0 0 3 10 8 0
1 0 0 2 10 8 0
0 1 0 2 10 8 0
1 0 1 2 10 8 0
0 1 1 2 10 8 0
1 1 0 2 10 8 0
0 0 1 1 10 8 0
1 0 0 2 10 8 0
0 0 0 2 10 8 0

// ==== fb_video.f ====
rtl/fb_video_pkg.sv
rtl/raster_timing.sv
rtl/pattern_writer.sv
rtl/vram_arbiter.sv
rtl/vram_reader.sv
rtl/video_out.sv
rtl/fb_video_top.sv
verification/fb_video_tb.sv

// ==== Makefile ====
# Verilator build and run of the frame-buffer display engine testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fb_video_tb
FILELIST  ?= fb_video.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
